// File: hex_dump.f
+incdir+include
source/hex_dump_pkg.sv
source/sync_fifo.sv
source/hex_word_encoder.sv
source/hex_dump_ctrl.sv
source/hex_dump_top.sv
test/hex_dump_tb.sv

// File: include/hex_dump_params.svh
`ifndef HEX_DUMP_PARAMS_SVH
`define HEX_DUMP_PARAMS_SVH

// Input buffer holds 16 beats
`define HEX_IN_ABITS 4

// Output buffer holds 64 characters
`define HEX_OUT_ABITS 6

// Width of the reported output buffer level
`define HEX_LEVEL_BITS (`HEX_OUT_ABITS + 1)

// Set to 1 for UTF-16 style output, a 0x00 byte before every character
`define HEX_WIDE_CHARS 0

`endif

// File: source/hex_dump_ctrl.sv
`timescale 1ns/1ps

module hex_dump_ctrl import hex_dump_pkg::*; #(
  parameter bit WIDE_CHARS = 1'b0
) (
  input  logic       clock,
  input  logic       reset,

  input  logic       start_dump_i,
  output logic       is_dumping_o,

  // Beats from the input buffer
  input  logic       in_valid_i,
  input  logic       in_last_i,
  input  logic [7:0] in_data_i,
  output logic       in_ready_o,

  // Encoder control
  output logic       load_lo_o,
  output logic       load_hi_o,
  output logic [7:0] byte_data_o,
  output logic       sep_newline_o,
  output char_sel_t  char_sel_o,
  input  logic [7:0] char_byte_i,

  // Write side of the output buffer
  output logic       f_valid_o,
  output logic       f_last_o,
  output logic [7:0] f_data_o,
  input  logic       f_ready_i,
  input  logic       out_empty_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CAP_LO,
    ST_CAP_HI,
    ST_EMIT,
    ST_DRAIN
  } state_t;

  state_t    state;
  char_sel_t sel;
  logic      char_phase;
  logic      pkt_last;
  logic      char_turn;
  logic      f_xfer;
  logic      group_done;

  // In wide mode the pad byte goes out while char_phase is low
  assign char_turn  = !WIDE_CHARS || char_phase;
  assign f_xfer     = f_valid_o && f_ready_i;
  assign group_done = f_xfer && char_turn && (sel == CHAR_SEL_SEP);

  assign in_ready_o    = (state == ST_CAP_LO) || (state == ST_CAP_HI);
  assign load_lo_o     = (state == ST_CAP_LO) && in_valid_i;
  assign load_hi_o     = (state == ST_CAP_HI) && in_valid_i;
  assign byte_data_o   = in_data_i;
  assign sep_newline_o = load_hi_o && in_last_i;
  assign char_sel_o    = sel;

  assign f_data_o = char_turn ? char_byte_i : CHAR_WIDE_PAD;
  // Only the newline closing the packet carries last, never its pad byte
  assign f_last_o = pkt_last && char_turn && (sel == CHAR_SEL_SEP);

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= ST_IDLE;
      is_dumping_o <= 1'b0;
      f_valid_o    <= 1'b0;
      sel          <= '0;
      char_phase   <= 1'b0;
      pkt_last     <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Beat stays in the buffer until the capture states take it
          if (in_valid_i && start_dump_i) begin
            is_dumping_o <= 1'b1;
            state        <= ST_CAP_LO;
          end
        end

        ST_CAP_LO: begin
          if (load_lo_o) begin
            state <= ST_CAP_HI;
          end
        end

        ST_CAP_HI: begin
          if (load_hi_o) begin
            pkt_last   <= in_last_i;
            sel        <= '0;
            char_phase <= 1'b0;
            state      <= ST_EMIT;
          end
        end

        ST_EMIT: begin
          if (group_done) begin
            f_valid_o <= 1'b0;
            state     <= pkt_last ? ST_DRAIN : ST_CAP_LO;
          end else begin
            f_valid_o <= 1'b1;
            if (f_xfer) begin
              if (char_turn) begin
                sel        <= sel + 3'd1;
                char_phase <= 1'b0;
              end else begin
                char_phase <= 1'b1;
              end
            end
          end
        end

        ST_DRAIN: begin
          // Busy until the console has taken every character
          if (out_empty_i) begin
            is_dumping_o <= 1'b0;
            state        <= ST_IDLE;
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  a_fvalid_in_emit: assert property (
    @(posedge clock) disable iff (reset)
    f_valid_o |-> state == ST_EMIT
  );

  // An offered character holds until the output buffer takes it
  a_offer_held: assert property (
    @(posedge clock) disable iff (reset)
    f_valid_o && !f_ready_i |=> f_valid_o && $stable(f_data_o) && $stable(f_last_o)
  );

endmodule

// File: source/hex_dump_pkg.sv
package hex_dump_pkg;

  // One byte from the input stream with its end-of-packet flag
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } stream_beat_t;

  // One byte for the console with its end-of-packet flag
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } out_char_t;

  // Character index in a group, 0 to 3 are digits, 4 is the separator
  typedef logic [2:0] char_sel_t;

  localparam char_sel_t CHAR_SEL_SEP = 3'd4;

  // Separators
  localparam logic [7:0] CHAR_SPACE   = 8'h20;
  localparam logic [7:0] CHAR_NEWLINE = 8'h0A;

  // Bases for the hex digits
  localparam logic [7:0] CHAR_DIGIT_0 = 8'h30;
  localparam logic [7:0] CHAR_HEX_A   = 8'h41;

  // High byte of a wide character
  localparam logic [7:0] CHAR_WIDE_PAD = 8'h00;

endpackage

// File: source/hex_dump_top.sv
`timescale 1ns/1ps
`include "hex_dump_params.svh"

module hex_dump_top import hex_dump_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,

  input  logic                       s_valid_i,
  output logic                       s_ready_o,
  input  logic                       s_last_i,
  input  logic [7:0]                 s_data_i,

  output logic                       m_valid_o,
  input  logic                       m_ready_i,
  output logic                       m_last_o,
  output logic [7:0]                 m_data_o,

  input  logic                       start_dump_i,
  output logic                       is_dumping_o,
  output logic [`HEX_LEVEL_BITS-1:0] fifo_level_o
);

  stream_beat_t s_beat;
  stream_beat_t in_beat;
  out_char_t    f_char;
  out_char_t    m_char;

  logic       in_valid;
  logic       in_ready;
  logic       load_lo;
  logic       load_hi;
  logic       sep_newline;
  logic       fvalid;
  logic       fready;
  logic       f_last;
  logic [7:0] byte_data;
  logic [7:0] char_byte;
  logic [7:0] f_data;
  char_sel_t  char_sel;

  assign s_beat.last = s_last_i;
  assign s_beat.data = s_data_i;

  assign f_char.last = f_last;
  assign f_char.data = f_data;

  assign m_last_o = m_char.last;
  assign m_data_o = m_char.data;

  sync_fifo #(
    .payload_t(stream_beat_t),
    .ABITS    (`HEX_IN_ABITS)
  ) u_in_fifo (
    .clock  (clock),
    .reset  (reset),
    .valid_i(s_valid_i),
    .ready_o(s_ready_o),
    .data_i (s_beat),
    .valid_o(in_valid),
    .ready_i(in_ready),
    .data_o (in_beat),
    .level_o()
  );

  hex_dump_ctrl #(
    .WIDE_CHARS(`HEX_WIDE_CHARS)
  ) u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .start_dump_i (start_dump_i),
    .is_dumping_o (is_dumping_o),
    .in_valid_i   (in_valid),
    .in_last_i    (in_beat.last),
    .in_data_i    (in_beat.data),
    .in_ready_o   (in_ready),
    .load_lo_o    (load_lo),
    .load_hi_o    (load_hi),
    .byte_data_o  (byte_data),
    .sep_newline_o(sep_newline),
    .char_sel_o   (char_sel),
    .char_byte_i  (char_byte),
    .f_valid_o    (fvalid),
    .f_last_o     (f_last),
    .f_data_o     (f_data),
    .f_ready_i    (fready),
    .out_empty_i  (!m_valid_o)
  );

  hex_word_encoder u_encoder (
    .clock        (clock),
    .reset        (reset),
    .load_lo_i    (load_lo),
    .load_hi_i    (load_hi),
    .byte_data_i  (byte_data),
    .sep_newline_i(sep_newline),
    .char_sel_i   (char_sel),
    .char_byte_o  (char_byte)
  );

  sync_fifo #(
    .payload_t(out_char_t),
    .ABITS    (`HEX_OUT_ABITS)
  ) u_out_fifo (
    .clock  (clock),
    .reset  (reset),
    .valid_i(fvalid),
    .ready_o(fready),
    .data_i (f_char),
    .valid_o(m_valid_o),
    .ready_i(m_ready_i),
    .data_o (m_char),
    .level_o(fifo_level_o)
  );

endmodule

// File: source/hex_word_encoder.sv
`timescale 1ns/1ps

module hex_word_encoder import hex_dump_pkg::*; (
  input  logic       clock,
  input  logic       reset,

  input  logic       load_lo_i,
  input  logic       load_hi_i,
  input  logic [7:0] byte_data_i,
  input  logic       sep_newline_i,
  input  char_sel_t  char_sel_i,

  output logic [7:0] char_byte_o
);

  // digit[3] is the high nibble of the high byte, digit[0] the low nibble of the low byte
  logic [7:0] digit [0:3];
  logic [7:0] sep_char;

  function automatic logic [7:0] nibble_to_hex(input logic [3:0] nib);
    logic [7:0] value;
    value = {4'h0, nib};
    if (nib < 4'd10) begin
      return CHAR_DIGIT_0 + value;
    end
    return CHAR_HEX_A + value - 8'd10;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      digit[0] <= CHAR_DIGIT_0;
      digit[1] <= CHAR_DIGIT_0;
      digit[2] <= CHAR_DIGIT_0;
      digit[3] <= CHAR_DIGIT_0;
      sep_char <= CHAR_SPACE;
    end else begin
      // First byte of the pair is printed last
      if (load_lo_i) begin
        digit[1] <= nibble_to_hex(byte_data_i[7:4]);
        digit[0] <= nibble_to_hex(byte_data_i[3:0]);
      end
      if (load_hi_i) begin
        digit[3] <= nibble_to_hex(byte_data_i[7:4]);
        digit[2] <= nibble_to_hex(byte_data_i[3:0]);
        sep_char <= sep_newline_i ? CHAR_NEWLINE : CHAR_SPACE;
      end
    end
  end

  // Most significant digit first, then the separator
  always_comb begin
    case (char_sel_i)
      3'd0: char_byte_o = digit[3];
      3'd1: char_byte_o = digit[2];
      3'd2: char_byte_o = digit[1];
      3'd3: char_byte_o = digit[0];
      CHAR_SEL_SEP: char_byte_o = sep_char;
      default: char_byte_o = CHAR_SPACE;
    endcase
  end

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  ABITS     = 4
) (
  input  logic           clock,
  input  logic           reset,

  // Write side
  input  logic           valid_i,
  output logic           ready_o,
  input  payload_t       data_i,

  // Read side
  output logic           valid_o,
  input  logic           ready_i,
  output payload_t       data_o,

  output logic [ABITS:0] level_o
);

  localparam logic [ABITS:0] DEPTH = 1 << ABITS;

  payload_t         mem [0:DEPTH-1];
  logic [ABITS-1:0] wr_ptr;
  logic [ABITS-1:0] rd_ptr;
  logic [ABITS:0]   count;
  logic             wr_en;
  logic             rd_en;
  logic             full;
  logic             empty;

  assign full  = (count == DEPTH);
  assign empty = (count == '0);

  assign ready_o = !full;
  assign valid_o = !empty;
  assign level_o = count;

  assign wr_en = valid_i && ready_o;
  assign rd_en = valid_o && ready_i;

  // Head of the buffer is visible as soon as it is written
  assign data_o = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at the power-of-two depth
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A pending write against a full buffer with no read must not land
  a_no_write_when_full: assert property (
    @(posedge clock) disable iff (reset)
    full && valid_i && !ready_i |=> full && $stable(wr_ptr)
  );

  a_level_bounded: assert property (
    @(posedge clock) disable iff (reset)
    level_o <= DEPTH
  );

endmodule

// File: test/hex_dump_stim.txt
// Packet list, all values in hex
// Columns: start flag, byte count, packet bytes; a count of 00 ends the list
1 04 00 FF 9A A9
1 02 12 34
0 06 01 23 45 67 89 AB
1 08 CD EF 5A A5 0F F0 3C C3
// Long packet, sent under heavy back-pressure
1 28
  00 11 22 33 44 55 66 77 88 99
  AA BB CC DD EE FF 10 32 54 76
  98 BA DC FE 01 02 03 04 05 06
  07 08 09 0A 0B 0C 0D 0E 0F 80
0 02 DE AD
1 06 B0 0B 5E 1F C0 DE
0 00

// File: test/hex_dump_tb.sv
`timescale 1ns/1ps
`include "hex_dump_params.svh"

module hex_dump_tb;

  localparam int TIMEOUT_CYCLES = 5000;
  localparam int GATE_CYCLES    = 24;
  localparam int STIM_WORDS     = 512;
  localparam int OUT_DEPTH      = 1 << `HEX_OUT_ABITS;

  logic                       clock = 1'b0;
  logic                       reset;
  logic                       s_valid_i;
  logic                       s_ready_o;
  logic                       s_last_i;
  logic [7:0]                 s_data_i;
  logic                       m_valid_o;
  logic                       m_ready_i;
  logic                       m_last_o;
  logic [7:0]                 m_data_o;
  logic                       start_dump_i;
  logic                       is_dumping_o;
  logic [`HEX_LEVEL_BITS-1:0] fifo_level_o;

  logic [7:0]  stim_mem [0:STIM_WORDS-1];
  // Expected output bytes with the last flag in bit 8
  logic [8:0]  exp_q [$];
  logic [31:0] lcg_state;
  int          ready_thresh;
  int          in_stalls;
  int          checks;
  int          errors;

  hex_dump_top DUT (
    .clock       (clock),
    .reset       (reset),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .s_last_i    (s_last_i),
    .s_data_i    (s_data_i),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .m_last_o    (m_last_o),
    .m_data_o    (m_data_o),
    .start_dump_i(start_dump_i),
    .is_dumping_o(is_dumping_o),
    .fifo_level_o(fifo_level_o)
  );

  initial begin
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    string digits;
    digits = "0123456789ABCDEF";
    return digits[nib];
  endfunction

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
    errors++;
  endtask

  task automatic push_char(input logic [7:0] c, input logic last);
    // Wide characters carry a zero byte in front
    if (`HEX_WIDE_CHARS) begin
      exp_q.push_back({1'b0, 8'h00});
    end
    exp_q.push_back({last, c});
  endtask

  // Each pair prints as the second byte, the first byte, then a separator
  task automatic expect_packet(input int base, input int count);
    logic [7:0] lo;
    logic [7:0] hi;
    logic       last_pair;
    for (int p = 0; p < count; p += 2) begin
      lo        = stim_mem[base + p];
      hi        = stim_mem[base + p + 1];
      last_pair = (p + 2 >= count);
      push_char(hex_char(hi[7:4]), 1'b0);
      push_char(hex_char(hi[3:0]), 1'b0);
      push_char(hex_char(lo[7:4]), 1'b0);
      push_char(hex_char(lo[3:0]), 1'b0);
      push_char(last_pair ? 8'h0A : 8'h20, last_pair);
    end
  endtask

  task automatic check_char();
    logic [8:0] expected;
    checks++;
    assert (exp_q.size() != 0) else begin
      $display("Unexpected character %02h on the output at %0t", m_data_o, $time);
      errors++;
    end
    if (exp_q.size() != 0) begin
      expected = exp_q.pop_front();
      checks += 2;
      assert (m_data_o == expected[7:0])
        else report_mismatch("m_data_o", m_data_o, expected[7:0]);
      assert (m_last_o == expected[8])
        else report_mismatch("m_last_o", m_last_o, expected[8]);
    end
  endtask

  // Random ready from the console and a check on every handshake
  always @(negedge clock) begin
    lcg_state = lcg_next(lcg_state);
    m_ready_i = (lcg_state[31:28] < ready_thresh);
    if (!reset) begin
      checks++;
      assert (fifo_level_o <= OUT_DEPTH) else begin
        $display("** Error at %0t: fifo_level_o is %0d, above the depth %0d",
                 $time, fifo_level_o, OUT_DEPTH);
        errors++;
      end
      if (m_valid_o && m_ready_i) begin
        check_char();
      end
    end
  end

  // Starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_beat(input logic [7:0] data, input logic last);
    int waited;
    waited    = 0;
    s_valid_i = 1'b1;
    s_data_i  = data;
    s_last_i  = last;
    while (!s_ready_o && waited < TIMEOUT_CYCLES) begin
      @(negedge clock);
      waited++;
    end
    if (!s_ready_o) begin
      $display("Timeout: s_ready_o stayed low for %0d cycles", TIMEOUT_CYCLES);
      errors++;
      finish_run();
    end else begin
      if (waited > 0) begin
        in_stalls++;
      end
      @(negedge clock);
      s_valid_i = 1'b0;
    end
  endtask

  task automatic wait_busy(input logic level);
    int waited;
    waited = 0;
    while (is_dumping_o !== level && waited < TIMEOUT_CYCLES) begin
      @(negedge clock);
      waited++;
    end
    if (is_dumping_o !== level) begin
      $display("Timeout: is_dumping_o did not become %0b within %0d cycles",
               level, TIMEOUT_CYCLES);
      errors++;
      finish_run();
    end
  endtask

  // Nothing may come out while start is held low
  task automatic check_gated();
    repeat (GATE_CYCLES) begin
      @(negedge clock);
      checks += 2;
      assert (m_valid_o == 1'b0) else report_mismatch("m_valid_o", m_valid_o, 0);
      assert (is_dumping_o == 1'b0) else report_mismatch("is_dumping_o", is_dumping_o, 0);
    end
  endtask

  task automatic run_packet(input int base, input logic flag, input int count);
    // Long packets get heavy back-pressure so both buffers fill
    ready_thresh = (count > 16) ? 3 : 12;
    start_dump_i = flag;
    expect_packet(base, count);
    for (int i = 0; i < count; i++) begin
      send_beat(stim_mem[base + i], i == count - 1);
    end
    if (!flag) begin
      check_gated();
      start_dump_i = 1'b1;
    end
    wait_busy(1'b1);
    wait_busy(1'b0);
    checks += 2;
    assert (exp_q.size() == 0) else begin
      $display("Dump ended at %0t with %0d characters missing", $time, exp_q.size());
      errors++;
    end
    assert (m_valid_o == 1'b0) else report_mismatch("m_valid_o", m_valid_o, 0);
  endtask

  initial begin
    int idx;
    int packets;
    reset        = 1'b1;
    s_valid_i    = 1'b0;
    s_last_i     = 1'b0;
    s_data_i     = 8'h00;
    m_ready_i    = 1'b0;
    start_dump_i = 1'b0;
    lcg_state    = 32'd36;
    ready_thresh = 12;
    in_stalls    = 0;
    checks       = 0;
    errors       = 0;
    $readmemh("test/hex_dump_stim.txt", stim_mem);

    repeat (10) @(negedge clock);
    reset = 1'b0;
    checks += 2;
    assert (is_dumping_o == 1'b0) else report_mismatch("is_dumping_o", is_dumping_o, 0);
    assert (s_ready_o == 1'b1) else report_mismatch("s_ready_o", s_ready_o, 1);

    idx     = 0;
    packets = 0;
    while (idx + 1 < STIM_WORDS && stim_mem[idx + 1] != 8'h00) begin
      run_packet(idx + 2, stim_mem[idx][0], stim_mem[idx + 1]);
      idx += stim_mem[idx + 1] + 2;
      packets++;
    end
    checks += 2;
    assert (packets > 0) else begin
      $display("No packets were read from the stimulus file");
      errors++;
    end
    assert (in_stalls > 0) else begin
      $display("s_ready_o never fell while the output was held back");
      errors++;
    end
    finish_run();
  end

endmodule
